// File: design/l2_pkg.sv
`default_nettype none

package l2_pkg;

    // stored tag width
    parameter int TAG_W = 18;

    // four ways, the age encoding depends on this
    parameter int WAYS = 4;
    parameter int WAY_W = 2;

    // age 0 is most recently used, age 3 is next to be replaced
    parameter int AGE_W = 2;

    typedef enum logic [1:0] {
        ST_IDLE       = 2'b00,
        ST_COMPARE    = 2'b01,
        ST_WRITE_BACK = 2'b10,
        ST_ALLOCATE   = 2'b11
    } l2_state_e;

endpackage

`default_nettype wire

// File: design/l2_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tag_store #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic [IDX_W-1:0]          index,
    input  logic [l2_pkg::TAG_W-1:0]  tag,
    input  logic [l2_pkg::WAY_W-1:0]  sel_way,
    input  logic                      fill,
    input  logic                      mark_dirty,
    input  logic                      invalidate_all,
    output logic                      hit,
    output logic [l2_pkg::WAY_W-1:0]  hit_way,
    output logic [l2_pkg::WAYS-1:0]   valid_ways,
    output logic                      sel_valid,
    output logic                      sel_dirty,
    output logic [l2_pkg::TAG_W-1:0]  sel_tag
);

    logic [l2_pkg::TAG_W-1:0] tag_mem [SETS][l2_pkg::WAYS];
    logic [SETS-1:0][l2_pkg::WAYS-1:0] valid_q;
    logic [SETS-1:0][l2_pkg::WAYS-1:0] dirty_q;

    logic [l2_pkg::WAYS-1:0] match;

    // compare request tag against every way of the set
    always_comb
    begin
        for (int w = 0; w < l2_pkg::WAYS; w++)
        begin
            match[w] = valid_q[index][w] && (tag_mem[index][w] == tag);
        end
    end

    assign hit = |match;

    // lowest matching way, only one should match anyway
    always_comb
    begin
        hit_way = '0;
        for (int w = l2_pkg::WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
                hit_way = l2_pkg::WAY_W'(w);
        end
    end

    assign valid_ways = valid_q[index];
    assign sel_valid  = valid_q[index][sel_way];
    assign sel_dirty  = dirty_q[index][sel_way];
    assign sel_tag    = tag_mem[index][sel_way];

    // tag payload
    always_ff @(posedge clk)
    begin
        if (fill)
            tag_mem[index][sel_way] <= tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_q <= '0;
        end
        else if (invalidate_all)
        begin
            valid_q <= '0;
        end
        else if (fill)
        begin
            valid_q[index][sel_way] <= 1'b1;
        end
    end

    // a fresh line is clean, a write hit dirties it
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            dirty_q <= '0;
        end
        else if (fill)
        begin
            dirty_q[index][sel_way] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty_q[index][sel_way] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/l2_lru.sv
`timescale 1ns/1ps
`default_nettype none

module l2_lru #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic [IDX_W-1:0]          index,
    input  logic [l2_pkg::WAYS-1:0]   valid_ways,
    input  logic                      touch,
    input  logic [l2_pkg::WAY_W-1:0]  touch_way,
    output logic [l2_pkg::WAY_W-1:0]  victim_way
);

    logic [SETS-1:0][l2_pkg::WAYS-1:0][l2_pkg::AGE_W-1:0] age_q;

    logic [l2_pkg::WAYS-1:0][l2_pkg::AGE_W-1:0] cur_age;
    logic [l2_pkg::WAYS-1:0][l2_pkg::AGE_W-1:0] next_age;
    logic [l2_pkg::AGE_W-1:0] touched_age;

    assign cur_age     = age_q[index];
    assign touched_age = cur_age[touch_way];

    // younger ways than the touched one move up by one
    always_comb
    begin
        for (int w = 0; w < l2_pkg::WAYS; w++)
        begin
            if (l2_pkg::WAY_W'(w) == touch_way)
                next_age[w] = '0;
            else if (cur_age[w] < touched_age)
                next_age[w] = cur_age[w] + 1'b1;
            else
                next_age[w] = cur_age[w];
        end
    end

    // lowest invalid way first, then the oldest one
    always_comb
    begin
        logic found;
        found = 1'b0;
        victim_way = '0;
        for (int w = 0; w < l2_pkg::WAYS; w++)
        begin
            if (!found && !valid_ways[w])
            begin
                victim_way = l2_pkg::WAY_W'(w);
                found = 1'b1;
            end
        end
        for (int w = 0; w < l2_pkg::WAYS; w++)
        begin
            if (!found && (cur_age[w] == l2_pkg::AGE_W'(l2_pkg::WAYS - 1)))
            begin
                victim_way = l2_pkg::WAY_W'(w);
                found = 1'b1;
            end
        end
    end

    // reset order puts way w at age w
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < l2_pkg::WAYS; w++)
                begin
                    age_q[s][w] <= l2_pkg::AGE_W'(w);
                end
            end
        end
        else if (touch)
        begin
            age_q[index] <= next_age;
        end
    end

endmodule

`default_nettype wire

// File: design/l2_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      read_l1_l2,
    input  logic                      write_l1_l2,
    input  logic                      flush,
    input  logic                      ready_mem_l2,
    input  logic [l2_pkg::TAG_W-1:0]  tag_l1_l2,
    input  logic                      hit,
    input  logic [l2_pkg::WAY_W-1:0]  hit_way,
    input  logic [l2_pkg::WAY_W-1:0]  victim_way,
    input  logic                      sel_valid,
    input  logic                      sel_dirty,
    input  logic [l2_pkg::TAG_W-1:0]  sel_tag,
    output logic [l2_pkg::WAY_W-1:0]  sel_way,
    output logic                      fill,
    output logic                      mark_dirty,
    output logic                      invalidate_all,
    output logic                      touch,
    output logic                      ready_l2_l1,
    output logic                      update,
    output logic                      refill,
    output logic                      read_l2_mem,
    output logic                      write_l2_mem,
    output logic [l2_pkg::TAG_W-1:0]  mem_tag,
    output logic [l2_pkg::WAY_W-1:0]  way
);

    l2_pkg::l2_state_e state_q;
    l2_pkg::l2_state_e state_d;

    logic [l2_pkg::WAY_W-1:0] way_q;
    logic ready_q;
    logic update_q;
    logic refill_q;

    logic request;
    logic in_idle;
    logic in_compare;
    logic in_write_back;
    logic in_allocate;

    assign request       = read_l1_l2 | write_l1_l2;
    assign in_idle       = (state_q == l2_pkg::ST_IDLE);
    assign in_compare    = (state_q == l2_pkg::ST_COMPARE);
    assign in_write_back = (state_q == l2_pkg::ST_WRITE_BACK);
    assign in_allocate   = (state_q == l2_pkg::ST_ALLOCATE);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            l2_pkg::ST_IDLE:
            begin
                if (request)
                    state_d = l2_pkg::ST_COMPARE;
            end
            l2_pkg::ST_COMPARE:
            begin
                // sel_valid and sel_dirty refer to the victim on a miss
                if (hit)
                    state_d = l2_pkg::ST_IDLE;
                else if (sel_valid && sel_dirty)
                    state_d = l2_pkg::ST_WRITE_BACK;
                else
                    state_d = l2_pkg::ST_ALLOCATE;
            end
            l2_pkg::ST_WRITE_BACK:
            begin
                if (ready_mem_l2)
                    state_d = l2_pkg::ST_ALLOCATE;
            end
            l2_pkg::ST_ALLOCATE:
            begin
                // retry the lookup once the line is in
                if (ready_mem_l2)
                    state_d = l2_pkg::ST_COMPARE;
            end
            default:
            begin
                state_d = l2_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state_q <= l2_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    // way held for write-back, allocate and the data array
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way_q <= '0;
        else if (in_compare && hit)
            way_q <= hit_way;
        else if (in_compare)
            way_q <= victim_way;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ready_q  <= 1'b0;
            update_q <= 1'b0;
            refill_q <= 1'b0;
        end
        else
        begin
            ready_q  <= in_compare && hit;
            update_q <= mark_dirty;
            refill_q <= fill;
        end
    end

    // in compare the store is steered straight from the lookup
    assign sel_way = in_compare ? (hit ? hit_way : victim_way) : way_q;

    assign touch          = in_compare && hit;
    assign mark_dirty     = in_compare && hit && write_l1_l2;
    assign fill           = in_allocate && ready_mem_l2;
    assign invalidate_all = in_idle && flush && !request;

    assign read_l2_mem  = in_allocate;
    assign write_l2_mem = in_write_back;
    assign mem_tag      = in_write_back ? sel_tag : tag_l1_l2;

    assign ready_l2_l1 = ready_q;
    assign update      = update_q;
    assign refill      = refill_q;
    assign way         = way_q;

endmodule

`default_nettype wire

// File: design/l2_tag_controller.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tag_controller #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS)
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      read_l1_l2,
    input  logic                      write_l1_l2,
    input  logic                      flush,
    input  logic [IDX_W-1:0]          index_l1_l2,
    input  logic [l2_pkg::TAG_W-1:0]  tag_l1_l2,
    input  logic                      ready_mem_l2,
    output logic                      ready_l2_l1,
    output logic                      refill,
    output logic                      update,
    output logic [l2_pkg::WAY_W-1:0]  way,
    output logic                      read_l2_mem,
    output logic                      write_l2_mem,
    output logic [IDX_W-1:0]          index_l2_mem,
    output logic [l2_pkg::TAG_W-1:0]  mem_tag
);

    logic [l2_pkg::WAY_W-1:0] sel_way;
    logic fill;
    logic mark_dirty;
    logic invalidate_all;
    logic touch;

    logic hit;
    logic [l2_pkg::WAY_W-1:0] hit_way;
    logic [l2_pkg::WAYS-1:0] valid_ways;
    logic sel_valid;
    logic sel_dirty;
    logic [l2_pkg::TAG_W-1:0] sel_tag;
    logic [l2_pkg::WAY_W-1:0] victim_way;

    // memory always works on the requested set
    assign index_l2_mem = index_l1_l2;

    l2_tag_store #(
        .SETS(SETS)
    ) i_l2_tag_store (
        .clk            (clk),
        .nrst           (nrst),
        .index          (index_l1_l2),
        .tag            (tag_l1_l2),
        .sel_way        (sel_way),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .invalidate_all (invalidate_all),
        .hit            (hit),
        .hit_way        (hit_way),
        .valid_ways     (valid_ways),
        .sel_valid      (sel_valid),
        .sel_dirty      (sel_dirty),
        .sel_tag        (sel_tag)
    );

    l2_lru #(
        .SETS(SETS)
    ) i_l2_lru (
        .clk        (clk),
        .nrst       (nrst),
        .index      (index_l1_l2),
        .valid_ways (valid_ways),
        .touch      (touch),
        .touch_way  (sel_way),
        .victim_way (victim_way)
    );

    l2_ctrl_fsm i_l2_ctrl_fsm (
        .clk            (clk),
        .nrst           (nrst),
        .read_l1_l2     (read_l1_l2),
        .write_l1_l2    (write_l1_l2),
        .flush          (flush),
        .ready_mem_l2   (ready_mem_l2),
        .tag_l1_l2      (tag_l1_l2),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .sel_valid      (sel_valid),
        .sel_dirty      (sel_dirty),
        .sel_tag        (sel_tag),
        .sel_way        (sel_way),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .invalidate_all (invalidate_all),
        .touch          (touch),
        .ready_l2_l1    (ready_l2_l1),
        .update         (update),
        .refill         (refill),
        .read_l2_mem    (read_l2_mem),
        .write_l2_mem   (write_l2_mem),
        .mem_tag        (mem_tag),
        .way            (way)
    );

endmodule

`default_nettype wire

// File: bench/l2_mem_responder.svh
`ifndef L2_MEM_RESPONDER_SVH
`define L2_MEM_RESPONDER_SVH

// called at 1 ns after the edge where a memory request is first seen
task automatic serve_memory_request();
    int unsigned latency;
    logic was_write;
    logic [l2_pkg::TAG_W-1:0] tag_seen;
    was_write = write_l2_mem;
    tag_seen = mem_tag;
    latency = $urandom % 4;
    #1;
    repeat (latency)
    begin
        @(posedge clk);
        #1;
        assert (was_write ? write_l2_mem : read_l2_mem)
        else fail_text("memory request dropped before it was acknowledged");
        #1;
    end
    ready_mem_l2 = 1'b1;
    // this edge completes the transfer
    @(posedge clk);
    #1;
    assert (!(was_write ? write_l2_mem : read_l2_mem))
    else fail_text("memory request still high after it was acknowledged");
    #1;
    ready_mem_l2 = 1'b0;
    if (was_write)
        wb_tags.push_back(tag_seen);
    else
        alloc_tags.push_back(tag_seen);
endtask

task automatic run_memory_responder();
    forever
    begin
        @(posedge clk);
        #1;
        assert (!(read_l2_mem && write_l2_mem))
        else fail_text("read and write to memory raised together");
        if (read_l2_mem || write_l2_mem)
            serve_memory_request();
    end
endtask

`endif

// File: bench/tb_l2_tag_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_tag_controller;

    localparam int SETS = 256;
    localparam int IDX_W = $clog2(SETS);
    localparam int RESET_CYCLES = 4;
    localparam int NUM_OPS = 20;
    localparam int CYCLE_LIMIT = NUM_OPS * 20 + RESET_CYCLES;

    localparam logic [l2_pkg::TAG_W-1:0] TAG_A = 18'h00a11;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_B = 18'h00b22;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_C = 18'h00c33;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_D = 18'h00d44;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_E = 18'h00e55;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_F = 18'h00f66;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_G = 18'h10077;
    localparam logic [l2_pkg::TAG_W-1:0] TAG_H = 18'h3ff88;
    localparam logic [l2_pkg::TAG_W-1:0] NO_TAG = 18'h00000;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } op_kind_e;

    typedef struct packed {
        op_kind_e                  kind;
        logic [IDX_W-1:0]          index;
        logic [l2_pkg::TAG_W-1:0]  tag;
        logic                      exp_hit;
        logic                      exp_wb;
        logic [l2_pkg::TAG_W-1:0]  exp_wb_tag;
        logic [l2_pkg::WAY_W-1:0]  exp_way;
    } op_t;

    logic clk;
    logic nrst;
    logic read_l1_l2;
    logic write_l1_l2;
    logic flush;
    logic [IDX_W-1:0] index_l1_l2;
    logic [l2_pkg::TAG_W-1:0] tag_l1_l2;
    logic ready_mem_l2;
    logic ready_l2_l1;
    logic refill;
    logic update;
    logic [l2_pkg::WAY_W-1:0] way;
    logic read_l2_mem;
    logic write_l2_mem;
    logic [IDX_W-1:0] index_l2_mem;
    logic [l2_pkg::TAG_W-1:0] mem_tag;

    op_t ops [NUM_OPS];
    logic [l2_pkg::TAG_W-1:0] wb_tags [$];
    logic [l2_pkg::TAG_W-1:0] alloc_tags [$];
    int error_count;
    int cycle_count;
    int op_num;
    int unsigned seed;

    l2_tag_controller #(
        .SETS(SETS)
    ) i_l2_tag_controller (
        .clk          (clk),
        .nrst         (nrst),
        .read_l1_l2   (read_l1_l2),
        .write_l1_l2  (write_l1_l2),
        .flush        (flush),
        .index_l1_l2  (index_l1_l2),
        .tag_l1_l2    (tag_l1_l2),
        .ready_mem_l2 (ready_mem_l2),
        .ready_l2_l1  (ready_l2_l1),
        .refill       (refill),
        .update       (update),
        .way          (way),
        .read_l2_mem  (read_l2_mem),
        .write_l2_mem (write_l2_mem),
        .index_l2_mem (index_l2_mem),
        .mem_tag      (mem_tag)
    );

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        error_count++;
        $display("** Error: %s = 0x%0h, expected 0x%0h (op %0d)", name, got, exp, op_num);
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_text(input string msg);
        error_count++;
        $display("error at op %0d: %s", op_num, msg);
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    `include "l2_mem_responder.svh"

    // expected ways follow from lowest invalid way, then age 3
    task automatic fill_op_table();
        ops[0]  = '{OP_READ,  8'h05, TAG_A, 1'b0, 1'b0, NO_TAG, 2'd0};
        ops[1]  = '{OP_READ,  8'h05, TAG_A, 1'b1, 1'b0, NO_TAG, 2'd0};
        ops[2]  = '{OP_WRITE, 8'h05, TAG_A, 1'b1, 1'b0, NO_TAG, 2'd0};
        ops[3]  = '{OP_READ,  8'h05, TAG_B, 1'b0, 1'b0, NO_TAG, 2'd1};
        ops[4]  = '{OP_WRITE, 8'h05, TAG_C, 1'b0, 1'b0, NO_TAG, 2'd2};
        ops[5]  = '{OP_READ,  8'h05, TAG_D, 1'b0, 1'b0, NO_TAG, 2'd3};
        ops[6]  = '{OP_READ,  8'h05, TAG_A, 1'b1, 1'b0, NO_TAG, 2'd0};
        ops[7]  = '{OP_READ,  8'h05, TAG_E, 1'b0, 1'b0, NO_TAG, 2'd1};
        // dirty C is the oldest and goes back on a read miss
        ops[8]  = '{OP_READ,  8'h05, TAG_F, 1'b0, 1'b1, TAG_C,  2'd2};
        ops[9]  = '{OP_WRITE, 8'h05, TAG_D, 1'b1, 1'b0, NO_TAG, 2'd3};
        ops[10] = '{OP_WRITE, 8'h05, TAG_G, 1'b0, 1'b1, TAG_A,  2'd0};
        ops[11] = '{OP_READ,  8'h05, TAG_B, 1'b0, 1'b0, NO_TAG, 2'd1};
        ops[12] = '{OP_READ,  8'h9c, TAG_A, 1'b0, 1'b0, NO_TAG, 2'd0};
        ops[13] = '{OP_WRITE, 8'h9c, TAG_H, 1'b0, 1'b0, NO_TAG, 2'd1};
        ops[14] = '{OP_FLUSH, 8'h00, NO_TAG, 1'b0, 1'b0, NO_TAG, 2'd0};
        // way 0 of set 05 held dirty G before the flush
        ops[15] = '{OP_READ,  8'h05, TAG_D, 1'b0, 1'b0, NO_TAG, 2'd0};
        ops[16] = '{OP_WRITE, 8'h9c, TAG_H, 1'b0, 1'b0, NO_TAG, 2'd0};
        ops[17] = '{OP_READ,  8'h05, TAG_D, 1'b1, 1'b0, NO_TAG, 2'd0};
        ops[18] = '{OP_READ,  8'h05, TAG_G, 1'b0, 1'b0, NO_TAG, 2'd1};
        ops[19] = '{OP_READ,  8'h9c, TAG_H, 1'b1, 1'b0, NO_TAG, 2'd0};
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        assert (!ready_l2_l1 && !read_l2_mem && !write_l2_mem)
        else fail_text("flush started a transfer");
        #1;
        flush = 1'b0;
        @(posedge clk);
        #2;
    endtask

    // entered and left at 2 ns after an edge
    task automatic apply_op(input op_t op);
        int cycles;
        int mem_cycles;
        int refill_count;
        int wb_before;
        int alloc_before;
        logic [l2_pkg::WAY_W-1:0] refill_way;
        cycles = 0;
        mem_cycles = 0;
        refill_count = 0;
        refill_way = '0;
        wb_before = wb_tags.size();
        alloc_before = alloc_tags.size();
        read_l1_l2 = (op.kind == OP_READ);
        write_l1_l2 = (op.kind == OP_WRITE);
        index_l1_l2 = op.index;
        tag_l1_l2 = op.tag;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (read_l2_mem || write_l2_mem)
            begin
                mem_cycles++;
                assert (index_l2_mem == op.index)
                else fail_value("index_l2_mem", index_l2_mem, op.index);
            end
            if (refill)
            begin
                refill_count++;
                refill_way = way;
            end
            assert (!update || ready_l2_l1)
            else fail_value("update", update, ready_l2_l1);
        end
        while (!ready_l2_l1);

        assert (way == op.exp_way)
        else fail_value("way", way, op.exp_way);
        assert (update == (op.kind == OP_WRITE))
        else fail_value("update", update, op.kind == OP_WRITE);
        assert (wb_tags.size() - wb_before == int'(op.exp_wb))
        else fail_text($sformatf("expected %0d write-backs, saw %0d",
                                 op.exp_wb, wb_tags.size() - wb_before));
        if (op.exp_wb)
        begin
            assert (wb_tags[$] == op.exp_wb_tag)
            else fail_value("mem_tag", wb_tags[$], op.exp_wb_tag);
        end
        if (op.exp_hit)
        begin
            assert (cycles == 2)
            else fail_text($sformatf("hit answered after %0d edges instead of 2", cycles));
            assert (mem_cycles == 0)
            else fail_text("memory request made on a hit");
            assert (refill_count == 0)
            else fail_text("refill pulse on a hit");
        end
        else
        begin
            assert (refill_count == 1)
            else fail_text($sformatf("expected one refill pulse, saw %0d", refill_count));
            assert (refill_way == op.exp_way)
            else fail_value("way", refill_way, op.exp_way);
            assert (alloc_tags.size() == alloc_before + 1)
            else fail_text("expected exactly one allocate request");
            assert (alloc_tags[$] == op.tag)
            else fail_value("mem_tag", alloc_tags[$], op.tag);
        end
        #1;
        read_l1_l2 = 1'b0;
        write_l1_l2 = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge clk);
            cycle_count++;
            assert (cycle_count < CYCLE_LIMIT)
            else fail_text("run did not finish within the cycle limit");
        end
    end

    initial
    begin
        error_count = 0;
        op_num = -1;
        seed = 78729;
        void'($urandom(seed));
        nrst = 1'b0;
        read_l1_l2 = 1'b0;
        write_l1_l2 = 1'b0;
        flush = 1'b0;
        index_l1_l2 = '0;
        tag_l1_l2 = '0;
        ready_mem_l2 = 1'b0;
        fill_op_table();
        fork
            run_memory_responder();
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        assert (!ready_l2_l1 && !refill && !update && !read_l2_mem && !write_l2_mem)
        else fail_text("control outputs not low during reset");
        #1;
        nrst = 1'b1;
        @(posedge clk);
        #2;

        for (int i = 0; i < NUM_OPS; i++)
        begin
            op_num = i;
            if (ops[i].kind == OP_FLUSH)
                apply_flush();
            else
                apply_op(ops[i]);
        end

        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+bench
design/l2_pkg.sv
design/l2_tag_store.sv
design/l2_lru.sv
design/l2_ctrl_fsm.sv
design/l2_tag_controller.sv
bench/tb_l2_tag_controller.sv

// File: Bender.yml
package:
  name: l2_tag_controller

sources:
  - design/l2_pkg.sv
  - design/l2_tag_store.sv
  - design/l2_lru.sv
  - design/l2_ctrl_fsm.sv
  - design/l2_tag_controller.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_l2_tag_controller.sv
